// ==== common/mcs_pkg.sv ====
package mcs_pkg;

    localparam int addr_w_c = 16;
    localparam int data_w_c = 8;

    // ~~~~~~~~~~~~~~~~~~~~
    // direct address map
    localparam logic [data_w_c-1:0] sfr_acc_c = 8'he0;
    localparam logic [data_w_c-1:0] sfr_psw_c = 8'hd0;
    localparam logic [data_w_c-1:0] sfr_dpl_c = 8'h82;
    localparam logic [data_w_c-1:0] sfr_dph_c = 8'h83;
    localparam logic [data_w_c-1:0] ram_top_c = 8'h7f;   // plain ram below this

    localparam int psw_cy_c = 7;                          // carry bit in psw

    // ~~~~~~~~~~~~~~~~~~~~
    // kept opcodes in their standard encodings
    typedef enum logic [data_w_c-1:0] {
        op_nop       = 8'h00,
        op_ljmp      = 8'h02,
        op_rr_a      = 8'h03,
        op_inc_a     = 8'h04,
        op_dec_a     = 8'h14,
        op_rl_a      = 8'h23,
        op_add_da    = 8'h24,
        op_add_di    = 8'h25,
        op_addc_da   = 8'h34,
        op_orl_da    = 8'h44,
        op_anl_da    = 8'h54,
        op_jz        = 8'h60,
        op_xrl_da    = 8'h64,
        op_jnz       = 8'h70,
        op_mov_a_da  = 8'h74,
        op_mov_di_da = 8'h75,
        op_sjmp      = 8'h80,
        op_mov_dptr  = 8'h90,
        op_subb_da   = 8'h94,
        op_inc_dptr  = 8'ha3,
        op_clr_c     = 8'hc3,
        op_swap_a    = 8'hc4,
        op_setb_c    = 8'hd3,
        op_clr_a     = 8'he4,
        op_mov_a_di  = 8'he5,
        op_movx_dp_a = 8'hf0,
        op_cpl_a     = 8'hf4,
        op_mov_di_a  = 8'hf5
    } opcode_e;

    typedef struct packed {
        opcode_e    op;
        logic [1:0] len;      // 1 to 3 bytes
        logic       rd_dir;   // reads a direct operand
        logic       wr_dir;   // writes a direct destination
        logic       branch;
    } dec_t;

    typedef struct packed {
        logic                en;
        logic [data_w_c-1:0] addr;
        logic [data_w_c-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic                en;
        logic [addr_w_c-1:0] addr;
        logic [data_w_c-1:0] data;
    } xram_wr_t;

    typedef struct packed {
        dec_t                dec;
        logic [data_w_c-1:0] byte2;
        logic [data_w_c-1:0] byte3;
        logic [data_w_c-1:0] operand;
    } exec_t;

endpackage

// ==== src/op_decode.sv ====
`timescale 1ns/1ns

module op_decode (
    input  logic [mcs_pkg::data_w_c-1:0] op_byte,
    output mcs_pkg::dec_t                dec
);

    always_comb begin
        dec     = '0;
        dec.op  = mcs_pkg::opcode_e'(op_byte);
        dec.len = 2'd1;
        case (op_byte)
            mcs_pkg::op_ljmp,
            mcs_pkg::op_mov_dptr,
            mcs_pkg::op_mov_di_da:
                dec.len = 2'd3;
            mcs_pkg::op_sjmp,
            mcs_pkg::op_jz,
            mcs_pkg::op_jnz,
            mcs_pkg::op_add_da,
            mcs_pkg::op_add_di,
            mcs_pkg::op_addc_da,
            mcs_pkg::op_subb_da,
            mcs_pkg::op_anl_da,
            mcs_pkg::op_orl_da,
            mcs_pkg::op_xrl_da,
            mcs_pkg::op_mov_a_da,
            mcs_pkg::op_mov_a_di,
            mcs_pkg::op_mov_di_a:
                dec.len = 2'd2;
            mcs_pkg::op_nop,
            mcs_pkg::op_inc_a,
            mcs_pkg::op_dec_a,
            mcs_pkg::op_clr_a,
            mcs_pkg::op_cpl_a,
            mcs_pkg::op_rl_a,
            mcs_pkg::op_rr_a,
            mcs_pkg::op_swap_a,
            mcs_pkg::op_inc_dptr,
            mcs_pkg::op_clr_c,
            mcs_pkg::op_setb_c,
            mcs_pkg::op_movx_dp_a:
                dec.len = 2'd1;
            default:
                dec.op = mcs_pkg::op_nop;       // unknown runs as nop
        endcase

        dec.rd_dir = (dec.op == mcs_pkg::op_add_di) || (dec.op == mcs_pkg::op_mov_a_di);
        dec.wr_dir = (dec.op == mcs_pkg::op_mov_di_a) || (dec.op == mcs_pkg::op_mov_di_da);
        dec.branch = (dec.op == mcs_pkg::op_ljmp) || (dec.op == mcs_pkg::op_sjmp) ||
                     (dec.op == mcs_pkg::op_jz)   || (dec.op == mcs_pkg::op_jnz);
    end

endmodule

// ==== fetch/fetch_ctrl.sv ====
`timescale 1ns/1ns

module fetch_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mcs_pkg::data_w_c-1:0]    rom_data,
    input  mcs_pkg::dec_t                   dec_now,
    input  mcs_pkg::dec_t                   dec1,
    input  logic [mcs_pkg::data_w_c-1:0]    operand,
    input  logic [mcs_pkg::data_w_c-1:0]    acc,
    output logic [mcs_pkg::addr_w_c-1:0]    rom_addr,
    output logic [mcs_pkg::data_w_c-1:0]    inst1,
    output mcs_pkg::exec_t                  slot,
    output logic                            exec_valid
);

    logic [mcs_pkg::addr_w_c-1:0]   pc_q;
    logic [mcs_pkg::data_w_c-1:0]   inst1_q;
    mcs_pkg::dec_t                  inst2_q;    // execute opcode kept decoded
    logic [2:0]                     first_q;    // rom_data, inst1, inst2 hold an opcode
    logic                           cond_ok;
    logic                           taken;
    logic                           more_bytes;
    logic [mcs_pkg::addr_w_c-1:0]   target;

    // ~~~~~~~~~~~~~~~~~~~~
    // branch resolve in execute
    always_comb begin
        case (inst2_q.op)
            mcs_pkg::op_jz:  cond_ok = (acc == '0);
            mcs_pkg::op_jnz: cond_ok = (acc != '0);
            default:         cond_ok = 1'b1;
        endcase
    end

    assign taken = first_q[2] && inst2_q.branch && cond_ok;

    // pc already points past a 2-byte branch here
    assign target = (inst2_q.op == mcs_pkg::op_ljmp) ? {inst1_q, rom_data} :
                    pc_q + {{8{inst1_q[7]}}, inst1_q};

    // ~~~~~~~~~~~~~~~~~~~~
    // first-byte tracker
    assign more_bytes = (first_q[0] && (dec_now.len != 2'd1)) ||
                        (first_q[1] && (dec1.len == 2'd3));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            first_q <= 3'b000;
        end else begin
            first_q <= {first_q[1] & ~taken,
                        first_q[0] & ~taken,
                        taken | ~more_bytes};   // target opcode arrives next
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc_q <= '0;
        end else if (taken) begin
            pc_q <= target;
        end else if (first_q != 3'b000) begin
            pc_q <= pc_q + 16'd1;               // held in the first cycle
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            inst1_q <= '0;
            inst2_q <= '0;
        end else begin
            inst1_q <= rom_data;
            inst2_q <= dec1;
        end
    end

    assign rom_addr   = pc_q;
    assign inst1      = inst1_q;
    assign exec_valid = first_q[2];
    assign slot       = '{dec: inst2_q, byte2: inst1_q, byte3: rom_data, operand: operand};

endmodule

// ==== exec/operand_addr.sv ====
`timescale 1ns/1ns

module operand_addr (
    input  logic                            clk,
    input  logic                            rst,
    input  mcs_pkg::dec_t                   dec1,
    input  logic [mcs_pkg::data_w_c-1:0]    rom_data,
    output logic [mcs_pkg::data_w_c-1:0]    rd_addr,
    input  logic [mcs_pkg::data_w_c-1:0]    rd_data,
    output logic [mcs_pkg::data_w_c-1:0]    operand
);

    // direct address is the byte behind the opcode in inst1
    assign rd_addr = dec1.rd_dir ? rom_data : '0;

    // operand ready for the execute cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            operand <= '0;
        end else if (dec1.rd_dir) begin
            operand <= rd_data;
        end
    end

endmodule

// ==== exec/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  mcs_pkg::exec_t                  slot,
    input  logic                            exec_valid,
    input  logic [mcs_pkg::data_w_c-1:0]    acc,
    input  logic [mcs_pkg::data_w_c-1:0]    psw,
    input  logic [mcs_pkg::addr_w_c-1:0]    dptr,
    output logic [mcs_pkg::data_w_c-1:0]    acc_next,
    output logic [mcs_pkg::data_w_c-1:0]    psw_next,
    output logic [mcs_pkg::addr_w_c-1:0]    dptr_next,
    output mcs_pkg::mem_wr_t                mem_wr,
    output mcs_pkg::xram_wr_t               xram_wr_next
);

    logic [mcs_pkg::data_w_c-1:0]   src;
    logic                           cy;
    logic [mcs_pkg::data_w_c:0]     sum;    // carry in the top bit

    assign src = slot.dec.rd_dir ? slot.operand : slot.byte2;
    assign cy  = psw[mcs_pkg::psw_cy_c];

    always_comb begin
        case (slot.dec.op)
            mcs_pkg::op_addc_da: sum = {1'b0, acc} + {1'b0, src} + 9'(cy);
            mcs_pkg::op_subb_da: sum = {1'b0, acc} - {1'b0, src} - 9'(cy);    // borrow
            default:             sum = {1'b0, acc} + {1'b0, src};
        endcase
    end

    always_comb begin
        acc_next  = acc;
        psw_next  = psw;
        dptr_next = dptr;
        if (exec_valid) begin
            case (slot.dec.op)
                mcs_pkg::op_add_da,
                mcs_pkg::op_add_di,
                mcs_pkg::op_addc_da,
                mcs_pkg::op_subb_da: begin
                    acc_next                   = sum[7:0];
                    psw_next[mcs_pkg::psw_cy_c] = sum[8];
                end
                mcs_pkg::op_anl_da:   acc_next = acc & src;
                mcs_pkg::op_orl_da:   acc_next = acc | src;
                mcs_pkg::op_xrl_da:   acc_next = acc ^ src;
                mcs_pkg::op_inc_a:    acc_next = acc + 8'd1;
                mcs_pkg::op_dec_a:    acc_next = acc - 8'd1;
                mcs_pkg::op_clr_a:    acc_next = '0;
                mcs_pkg::op_cpl_a:    acc_next = ~acc;
                mcs_pkg::op_rl_a:     acc_next = {acc[6:0], acc[7]};
                mcs_pkg::op_rr_a:     acc_next = {acc[0], acc[7:1]};
                mcs_pkg::op_swap_a:   acc_next = {acc[3:0], acc[7:4]};
                mcs_pkg::op_mov_a_da,
                mcs_pkg::op_mov_a_di: acc_next = src;
                mcs_pkg::op_mov_dptr: dptr_next = {slot.byte2, slot.byte3};
                mcs_pkg::op_inc_dptr: dptr_next = dptr + 16'd1;
                mcs_pkg::op_clr_c:    psw_next[mcs_pkg::psw_cy_c] = 1'b0;
                mcs_pkg::op_setb_c:   psw_next[mcs_pkg::psw_cy_c] = 1'b1;
                default: ;                                      // nop, branches, stores
            endcase
        end
    end

    // direct store destination is always byte 2
    assign mem_wr.en   = exec_valid && slot.dec.wr_dir;
    assign mem_wr.addr = slot.byte2;
    assign mem_wr.data = (slot.dec.op == mcs_pkg::op_mov_di_a) ? acc : slot.byte3;

    assign xram_wr_next.en   = exec_valid && (slot.dec.op == mcs_pkg::op_movx_dp_a);
    assign xram_wr_next.addr = dptr;
    assign xram_wr_next.data = acc;

endmodule

// ==== exec/data_mem.sv ====
`timescale 1ns/1ns

module data_mem (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mcs_pkg::data_w_c-1:0]    rd_addr,
    output logic [mcs_pkg::data_w_c-1:0]    rd_data,
    input  logic [mcs_pkg::data_w_c-1:0]    acc_next,
    input  logic [mcs_pkg::data_w_c-1:0]    psw_next,
    input  logic [mcs_pkg::addr_w_c-1:0]    dptr_next,
    input  mcs_pkg::mem_wr_t                mem_wr,
    input  mcs_pkg::xram_wr_t               xram_wr_next,
    output logic [mcs_pkg::data_w_c-1:0]    acc,
    output logic [mcs_pkg::data_w_c-1:0]    psw,
    output logic [mcs_pkg::addr_w_c-1:0]    dptr,
    output mcs_pkg::xram_wr_t               xram_wr
);

    logic [mcs_pkg::data_w_c-1:0]   ram [0:127];
    logic [mcs_pkg::data_w_c-1:0]   dpl;
    logic [mcs_pkg::data_w_c-1:0]   dph;
    logic                           ram_wr;
    logic                           xram_en_q;
    logic [mcs_pkg::addr_w_c-1:0]   xram_addr_q;
    logic [mcs_pkg::data_w_c-1:0]   xram_data_q;

    function automatic logic sfr_hit(input mcs_pkg::mem_wr_t wr,
                                     input logic [mcs_pkg::data_w_c-1:0] addr);
        return wr.en && (wr.addr == addr);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // plain ram in the lower half of direct space
    assign ram_wr = mem_wr.en && (mem_wr.addr <= mcs_pkg::ram_top_c);

    always_ff @(posedge clk) begin
        if (ram_wr) begin
            ram[mem_wr.addr[6:0]] <= mem_wr.data;
        end
    end

    always_comb begin
        if (rd_addr <= mcs_pkg::ram_top_c) begin
            rd_data = ram[rd_addr[6:0]];
        end else begin
            case (rd_addr)
                mcs_pkg::sfr_acc_c: rd_data = acc;
                mcs_pkg::sfr_psw_c: rd_data = psw;
                mcs_pkg::sfr_dpl_c: rd_data = dpl;
                mcs_pkg::sfr_dph_c: rd_data = dph;
                default:            rd_data = '0;   // unmapped sfr
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // a direct store to an sfr wins over the alu result
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc <= '0;
            psw <= '0;
            dpl <= '0;
            dph <= '0;
        end else begin
            acc <= sfr_hit(mem_wr, mcs_pkg::sfr_acc_c) ? mem_wr.data : acc_next;
            psw <= sfr_hit(mem_wr, mcs_pkg::sfr_psw_c) ? mem_wr.data : psw_next;
            dpl <= sfr_hit(mem_wr, mcs_pkg::sfr_dpl_c) ? mem_wr.data : dptr_next[7:0];
            dph <= sfr_hit(mem_wr, mcs_pkg::sfr_dph_c) ? mem_wr.data : dptr_next[15:8];
        end
    end

    assign dptr = {dph, dpl};

    // ~~~~~~~~~~~~~~~~~~~~
    // external write one cycle behind execute
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            xram_en_q <= 1'b0;
        end else begin
            xram_en_q <= xram_wr_next.en;
        end
    end

    always_ff @(posedge clk) begin
        if (xram_wr_next.en) begin
            xram_addr_q <= xram_wr_next.addr;
            xram_data_q <= xram_wr_next.data;
        end
    end

    assign xram_wr = '{en: xram_en_q, addr: xram_addr_q, data: xram_data_q};

endmodule

// ==== src/core_top.sv ====
`timescale 1ns/1ns

module core_top (
    input  logic                            clk,
    input  logic                            rst,
    output logic [mcs_pkg::addr_w_c-1:0]    rom_addr,
    input  logic [mcs_pkg::data_w_c-1:0]    rom_data,
    output mcs_pkg::xram_wr_t               xram_wr
);

    mcs_pkg::dec_t                  dec_now;
    mcs_pkg::dec_t                  dec1;
    mcs_pkg::exec_t                 slot;
    mcs_pkg::mem_wr_t               mem_wr;
    mcs_pkg::xram_wr_t              xram_wr_next;
    logic                           exec_valid;
    logic [mcs_pkg::data_w_c-1:0]   inst1;
    logic [mcs_pkg::data_w_c-1:0]   rd_addr;
    logic [mcs_pkg::data_w_c-1:0]   rd_data;
    logic [mcs_pkg::data_w_c-1:0]   operand;
    logic [mcs_pkg::data_w_c-1:0]   acc;
    logic [mcs_pkg::data_w_c-1:0]   psw;
    logic [mcs_pkg::data_w_c-1:0]   acc_next;
    logic [mcs_pkg::data_w_c-1:0]   psw_next;
    logic [mcs_pkg::addr_w_c-1:0]   dptr;
    logic [mcs_pkg::addr_w_c-1:0]   dptr_next;

    op_decode u_dec_now (.op_byte(rom_data), .dec(dec_now));    // length tracking
    op_decode u_dec_inst1 (.op_byte(inst1), .dec(dec1));        // operand addressing

    fetch_ctrl u_fetch_ctrl (
        .clk        (clk),
        .rst        (rst),
        .rom_data   (rom_data),
        .dec_now    (dec_now),
        .dec1       (dec1),
        .operand    (operand),
        .acc        (acc),
        .rom_addr   (rom_addr),
        .inst1      (inst1),
        .slot       (slot),
        .exec_valid (exec_valid)
    );

    operand_addr u_operand_addr (
        .clk        (clk),
        .rst        (rst),
        .dec1       (dec1),
        .rom_data   (rom_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .operand    (operand)
    );

    alu u_alu (
        .slot         (slot),
        .exec_valid   (exec_valid),
        .acc          (acc),
        .psw          (psw),
        .dptr         (dptr),
        .acc_next     (acc_next),
        .psw_next     (psw_next),
        .dptr_next    (dptr_next),
        .mem_wr       (mem_wr),
        .xram_wr_next (xram_wr_next)
    );

    data_mem u_data_mem (
        .clk          (clk),
        .rst          (rst),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .acc_next     (acc_next),
        .psw_next     (psw_next),
        .dptr_next    (dptr_next),
        .mem_wr       (mem_wr),
        .xram_wr_next (xram_wr_next),
        .acc          (acc),
        .psw          (psw),
        .dptr         (dptr),
        .xram_wr      (xram_wr)
    );

endmodule

// ==== bench/core_ref.svh ====
// ~~~~~~~~~~~~~~~~~~~~
// program image

function automatic void emit(input int n, input logic [7:0] b0, input logic [7:0] b1,
                             input logic [7:0] b2);
    rom[plen] = b0;
    if (n > 1) rom[plen + 1] = b1;
    if (n > 2) rom[plen + 2] = b2;
    plen += n;
endfunction

// one non-branch instruction that returns 1 for a direct store
function automatic logic emit_plain(input logic after_wr);
    int unsigned sel;
    logic [7:0]  ad;
    logic [7:0]  r;
    sel = $urandom % 24;
    ad  = 8'h30 + 8'($urandom % 8);
    r   = 8'($urandom);
    if (after_wr && (sel == 14 || sel == 15)) begin
        sel = 6;                                        // no read right after a store
    end
    case (sel)
        0:  emit(2, 8'h24, r, 8'h00);                   // add a,#imm
        1:  emit(2, 8'h34, r, 8'h00);                   // addc a,#imm
        2:  emit(2, 8'h94, r, 8'h00);                   // subb a,#imm
        3:  emit(2, 8'h54, r, 8'h00);
        4:  emit(2, 8'h44, r, 8'h00);
        5:  emit(2, 8'h64, r, 8'h00);
        6:  emit(1, 8'h04, 8'h00, 8'h00);               // inc a
        7:  emit(1, 8'h14, 8'h00, 8'h00);
        8:  emit(1, 8'he4, 8'h00, 8'h00);
        9:  emit(1, 8'hf4, 8'h00, 8'h00);
        10: emit(1, 8'h23, 8'h00, 8'h00);               // rl a
        11: emit(1, 8'h03, 8'h00, 8'h00);
        12: emit(1, 8'hc4, 8'h00, 8'h00);
        13: emit(2, 8'h74, r, 8'h00);                   // mov a,#imm
        14: emit(2, 8'he5, ad, 8'h00);                  // mov a,direct
        15: emit(2, 8'h25, ad, 8'h00);                  // add a,direct
        16: emit(2, 8'hf5, ad, 8'h00);                  // mov direct,a
        17: emit(3, 8'h75, ad, r);
        18: emit(3, 8'h90, r, 8'($urandom));            // mov dptr,#imm16
        19: emit(1, 8'ha3, 8'h00, 8'h00);
        20: emit(1, 8'hc3, 8'h00, 8'h00);
        21: emit(1, 8'hd3, 8'h00, 8'h00);
        22: emit(1, 8'h00, 8'h00, 8'h00);
        default: emit(1, 8'hf0, 8'h00, 8'h00);          // movx @dptr,a
    endcase
    return (sel == 16) || (sel == 17);
endfunction

function automatic void gen_program();
    logic       wr;
    logic [7:0] bop;
    int         at;
    plen = 0;
    for (int i = 0; i < rom_size_c; i++) begin
        rom[i] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 3);       // filler behind the program
    end
    for (int a = 0; a < 8; a++) begin
        emit(3, 8'h75, 8'h30 + 8'(a), 8'($urandom));    // preset the used ram bytes
    end
    wr = 1'b1;
    for (int i = 0; i < items_c; i++) begin
        if (i % 3 == 2) begin
            emit(1, 8'hf0, 8'h00, 8'h00);
            wr = 1'b0;
        end else if ($urandom % 6 == 0) begin
            case ($urandom % 4)
                0: bop = 8'h80;
                1: bop = 8'h60;
                2: bop = 8'h70;
                default: bop = 8'h02;
            endcase
            if ((bop == 8'h60 || bop == 8'h70) && ($urandom % 2 == 1)) begin
                emit(1, 8'he4, 8'h00, 8'h00);           // zero acc ahead of jz/jnz
                wr = 1'b0;
            end
            at = plen;
            emit(bop == 8'h02 ? 3 : 2, bop, 8'h00, 8'h00);
            repeat (1 + $urandom % 3) wr = emit_plain(wr);
            if (bop == 8'h02) begin
                rom[at + 1] = 8'(plen >> 8);
                rom[at + 2] = 8'(plen);
            end else begin
                rom[at + 1] = 8'(plen - at - 2);        // forward over the block
            end
        end else begin
            wr = emit_plain(wr);
        end
    end
    emit(2, 8'h80, 8'hfe, 8'h00);                       // sjmp to itself
endfunction

// ~~~~~~~~~~~~~~~~~~~~
// instruction set model that fills exp_q

function automatic void ref_model();
    logic [7:0]  ram [0:127];
    logic [7:0]  a;
    logic [7:0]  op;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic        cy;
    logic [15:0] pc;
    logic [15:0] dp;
    a  = 8'h00;
    cy = 1'b0;
    pc = 16'h0000;
    dp = 16'h0000;
    exp_q.delete();
    for (int step = 0; step < 4 * rom_size_c; step++) begin
        op = rom[pc[9:0]];
        b1 = rom[10'(pc + 16'd1)];
        b2 = rom[10'(pc + 16'd2)];
        if (op == 8'h80 && b1 == 8'hfe) begin
            break;
        end
        case (op)
            8'h02, 8'h75, 8'h90: pc = pc + 16'd3;
            8'h00, 8'h03, 8'h04, 8'h14, 8'h23, 8'ha3, 8'hc3, 8'hc4, 8'hd3, 8'he4,
            8'hf0, 8'hf4: pc = pc + 16'd1;
            default: pc = pc + 16'd2;
        endcase
        case (op)
            8'h02: pc = {b1, b2};
            8'h80: pc = pc + {{8{b1[7]}}, b1};
            8'h60: if (a == 8'h00) pc = pc + {{8{b1[7]}}, b1};
            8'h70: if (a != 8'h00) pc = pc + {{8{b1[7]}}, b1};
            8'h24: {cy, a} = 9'(int'(a) + int'(b1));
            8'h34: {cy, a} = 9'(int'(a) + int'(b1) + int'(cy));
            8'h94: {cy, a} = 9'(int'(a) - int'(b1) - int'(cy));   // borrow in bit 8
            8'h25: {cy, a} = 9'(int'(a) + int'(ram[b1[6:0]]));
            8'h54: a = a & b1;
            8'h44: a = a | b1;
            8'h64: a = a ^ b1;
            8'h04: a = a + 8'd1;
            8'h14: a = a - 8'd1;
            8'he4: a = 8'h00;
            8'hf4: a = ~a;
            8'h23: a = 8'((a << 1) | (a >> 7));
            8'h03: a = 8'((a >> 1) | (a << 7));
            8'hc4: a = 8'((a << 4) | (a >> 4));
            8'h74: a = b1;
            8'he5: a = ram[b1[6:0]];
            8'hf5: ram[b1[6:0]] = a;
            8'h75: ram[b1[6:0]] = b2;
            8'h90: dp = {b1, b2};
            8'ha3: dp = dp + 16'd1;
            8'hc3: cy = 1'b0;
            8'hd3: cy = 1'b1;
            8'hf0: exp_q.push_back({1'b1, dp, a});
            default: ;
        endcase
    end
endfunction

// ==== bench/tb_core.sv ====
`timescale 1ns/1ns

module tb_core;

    localparam int rom_size_c = 1024;
    localparam int items_c    = 60;

    logic                           clk;
    logic                           rst;
    logic [mcs_pkg::addr_w_c-1:0]   rom_addr;
    logic [mcs_pkg::data_w_c-1:0]   rom_data;
    mcs_pkg::xram_wr_t              xram_wr;

    logic [7:0]                     rom [0:rom_size_c-1];
    int                             plen;
    mcs_pkg::xram_wr_t              exp_q [$];
    int                             n_exp;
    int                             n_writes;
    int                             errors;
    int                             cycles;
    int                             limit;
    logic [mcs_pkg::addr_w_c-1:0]   loop_addr;
    logic                           watch_on;   // set once reset is applied

    `include "core_ref.svh"

    core_top u_core_top (
        .clk      (clk),
        .rst      (rst),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .xram_wr  (xram_wr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // rom answers in the same cycle
    always @(posedge clk) begin
        #1;
        rom_data = rom[rom_addr[9:0]];
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // checks

    task automatic check_write(input mcs_pkg::xram_wr_t got, input mcs_pkg::xram_wr_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: xram write addr %h data %h, expected addr %h data %h",
                     $time, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    task automatic check_addr(input logic [mcs_pkg::addr_w_c-1:0] got,
                              input logic [mcs_pkg::addr_w_c-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: rom_addr %h %s, expected %h", $time, got, what, exp);
        end
    endtask

    always @(negedge clk) begin
        if (watch_on) begin
            if (!rst) begin
                if (xram_wr.en !== 1'b0) begin
                    errors++;
                    $display("external write enable not low during reset at %0t ns", $time);
                end
            end else if (xram_wr.en === 1'b1) begin
                n_writes++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("external write at %0t ns when none was expected", $time);
                end else begin
                    check_write(xram_wr, exp_q.pop_front());
                end
            end else if (xram_wr.en !== 1'b0) begin
                errors++;
                $display("external write enable unknown at %0t ns", $time);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // main sequence

    initial begin
        void'($urandom(57));
        rst      = 1'b1;
        rom_data = '0;
        watch_on = 1'b0;
        errors   = 0;
        n_writes = 0;
        cycles   = 0;
        gen_program();
        ref_model();
        n_exp     = exp_q.size();
        limit     = 4 * plen + 100;
        loop_addr = 16'(plen - 2);
        #1;
        rst      = 1'b0;
        watch_on = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_addr(rom_addr, '0, "during reset");
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_addr(rom_addr, '0, "after the first clock out of reset");

        while (!(exp_q.size() == 0 && rom_addr == loop_addr) && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= limit) begin
            errors++;
            $display("timeout after %0d cycles, %0d writes never arrived", cycles, exp_q.size());
        end else begin
            repeat (16) @(negedge clk);                     // stray writes behind the loop
            if (n_writes != n_exp) begin
                errors++;
                $display("saw %0d external writes but %0d were expected", n_writes, n_exp);
            end
        end

        $display("errors %0d, writes %0d of %0d, program %0d bytes", errors, n_writes, n_exp,
                 plen);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+bench
common/mcs_pkg.sv
src/op_decode.sv
fetch/fetch_ctrl.sv
exec/operand_addr.sv
exec/alu.sv
exec/data_mem.sv
src/core_top.sv
bench/tb_core.sv
